// File: src/viterbi_code_pkg.sv
`default_nettype none

package viterbi_code_pkg;

   // trellis shape
   localparam int NUM_STATES = 8;
   localparam int STATE_W    = 3;
   localparam int SYM_W      = 2;
   localparam int METRIC_W   = 8;

   // generator taps, bit order {input bit, s2, s1, s0}
   localparam logic [3:0] GEN_0 = 4'b1111;   // symbol bit 0
   localparam logic [3:0] GEN_1 = 4'b1101;   // symbol bit 1

   typedef logic [SYM_W-1:0]      sym_t;
   typedef logic [METRIC_W-1:0]   metric_t;
   typedef logic [NUM_STATES-1:0] decision_t;   // survivor bit x per state
   typedef logic [STATE_W-1:0]    state_t;      // s2 is the newest input

endpackage

`default_nettype wire

// File: src/viterbi_mem_pkg.sv
`default_nettype none

package viterbi_mem_pkg;

   localparam int NUM_BANKS = 4;

   // survivor banks, written in rotation A, B, C, D
   typedef enum logic [1:0] {
      BANK_A,
      BANK_B,
      BANK_C,
      BANK_D
   } bank_e;

   typedef enum logic [1:0] {
      TB_IDLE,
      TB_TRAIN,    // walk back without output
      TB_DECODE    // walk back and emit bits
   } tb_phase_e;

   typedef enum logic {
      SIDE_0,
      SIDE_1
   } side_e;

endpackage

`default_nettype wire

// File: src/decision_ram.sv
`timescale 1ns/1ps
`default_nettype none

module decision_ram #(
   parameter  int TB_DEPTH = 16,
   localparam int ADDR_W   = $clog2(TB_DEPTH)
) (
   input  logic                        clk,
   input  logic                        wr_en_i,
   input  logic [ADDR_W-1:0]           wr_addr_i,
   input  viterbi_code_pkg::decision_t wr_data_i,
   input  logic [ADDR_W-1:0]           rd_addr_i,
   output viterbi_code_pkg::decision_t rd_data_o
);

   viterbi_code_pkg::decision_t mem [TB_DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
      rd_data_o <= mem[rd_addr_i];   // old data on same-address write
   end

endmodule

`default_nettype wire

// File: src/path_metric_unit.sv
`timescale 1ns/1ps
`default_nettype none

module path_metric_unit (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        enable_i,
   input  viterbi_code_pkg::sym_t      sym_i,
   input  logic                        sym_valid_i,
   output viterbi_code_pkg::decision_t decision_o,
   output logic                        dec_valid_o
);

   localparam int N = viterbi_code_pkg::NUM_STATES;

   viterbi_code_pkg::metric_t   metric_q [N];
   viterbi_code_pkg::metric_t   metric_d [N];
   logic [N-1:0]                valid_q;       // state reached since stream start
   logic [N-1:0]                valid_d;
   viterbi_code_pkg::decision_t select_d;
   logic                        norm;          // every metric MSB set

   // hamming distance between the symbol and the label of branch (prev, b)
   function automatic logic [1:0] branch_dist(input viterbi_code_pkg::sym_t   sym,
                                              input viterbi_code_pkg::state_t prev,
                                              input logic                     b);
      logic [3:0]             taps;
      viterbi_code_pkg::sym_t label;
      viterbi_code_pkg::sym_t diff;
      taps  = {b, prev};
      label = {^(taps & viterbi_code_pkg::GEN_1), ^(taps & viterbi_code_pkg::GEN_0)};
      diff  = sym ^ label;
      return {diff[1] & diff[0], diff[1] ^ diff[0]};
   endfunction

   // ----------------------------------------
   // add-compare-select
   // ----------------------------------------
   always_comb begin
      viterbi_code_pkg::state_t  ns;
      viterbi_code_pkg::state_t  p0;
      viterbi_code_pkg::state_t  p1;
      viterbi_code_pkg::metric_t sum0;
      viterbi_code_pkg::metric_t sum1;
      logic                      take1;
      norm = 1'b1;
      for (int i = 0; i < N; i++) begin
         norm = norm & metric_q[i][viterbi_code_pkg::METRIC_W-1];
      end
      for (int n = 0; n < N; n++) begin
         ns    = viterbi_code_pkg::state_t'(n);
         p0    = {ns[1:0], 1'b0};   // predecessors differ only in the oldest bit
         p1    = {ns[1:0], 1'b1};
         sum0  = metric_q[p0] + branch_dist(sym_i, p0, ns[2]);
         sum1  = metric_q[p1] + branch_dist(sym_i, p1, ns[2]);
         // invalid predecessors drop out, ties keep x = 0
         take1 = valid_q[p1] && (!valid_q[p0] || sum1 < sum0);
         select_d[n] = take1;
         valid_d[n]  = valid_q[p0] | valid_q[p1];
         metric_d[n] = take1 ? sum1 : sum0;
         if (norm) begin
            metric_d[n][viterbi_code_pkg::METRIC_W-1] = 1'b0;   // subtract half range
         end
      end
   end

   // ----------------------------------------
   // metric registers
   // ----------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         metric_q    <= '{default: '0};
         valid_q     <= N'(1);       // only state 0 at start
         decision_o  <= '0;
         dec_valid_o <= 1'b0;
      end else if (!enable_i) begin
         metric_q    <= '{default: '0};
         valid_q     <= N'(1);
         dec_valid_o <= 1'b0;
      end else if (sym_valid_i) begin
         metric_q    <= metric_d;
         valid_q     <= valid_d;
         decision_o  <= select_d;
         dec_valid_o <= 1'b1;
      end else begin
         dec_valid_o <= 1'b0;
      end
   end

   // the trellis never runs out of reachable states
   assert property (@(posedge clk) disable iff (!rst) valid_q != '0)
      else $error("path_metric_unit: no valid state");

endmodule

`default_nettype wire

// File: src/survivor_memory.sv
`timescale 1ns/1ps
`default_nettype none

module survivor_memory #(
   parameter  int TB_DEPTH = 16,
   localparam int ADDR_W   = $clog2(TB_DEPTH)
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        enable_i,
   input  viterbi_code_pkg::decision_t decision_i,
   input  logic                        dec_valid_i,
   output logic [1:0]                  start_o,
   output viterbi_mem_pkg::bank_e      train_bank_o,
   output viterbi_mem_pkg::bank_e      dec_bank_o,
   input  viterbi_mem_pkg::bank_e      rd_bank_0_i,
   input  viterbi_mem_pkg::bank_e      rd_bank_1_i,
   input  logic [ADDR_W-1:0]           rd_addr_0_i,
   input  logic [ADDR_W-1:0]           rd_addr_1_i,
   output viterbi_code_pkg::decision_t rd_data_0_o,
   output viterbi_code_pkg::decision_t rd_data_1_o
);

   viterbi_mem_pkg::bank_e      wr_bank;
   logic [ADDR_W-1:0]           wr_addr;
   logic                        primed;      // first bank filled
   logic                        unit_sel;    // unit that gets the next start
   logic [1:0]                  busy;        // units walking the trellis
   logic                        bank_done;
   viterbi_mem_pkg::bank_e      rd_bank_0_q;
   viterbi_mem_pkg::bank_e      rd_bank_1_q;
   viterbi_code_pkg::decision_t bank_rd_data [viterbi_mem_pkg::NUM_BANKS];

   // start is issued with the last write so training reads begin next cycle
   assign bank_done    = dec_valid_i && wr_addr == ADDR_W'(TB_DEPTH - 1);
   assign start_o      = (bank_done && primed) ? (unit_sel ? 2'b10 : 2'b01) : 2'b00;
   assign train_bank_o = wr_bank;
   assign dec_bank_o   = viterbi_mem_pkg::bank_e'(wr_bank - 2'd1);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wr_bank  <= viterbi_mem_pkg::BANK_A;
         wr_addr  <= '0;
         primed   <= 1'b0;
         unit_sel <= 1'b0;
         busy     <= 2'b00;
      end else if (!enable_i) begin
         wr_bank  <= viterbi_mem_pkg::BANK_A;
         wr_addr  <= '0;
         primed   <= 1'b0;
         unit_sel <= 1'b0;
         busy     <= 2'b00;
      end else begin
         if (bank_done) begin
            wr_addr <= '0;
            wr_bank <= viterbi_mem_pkg::bank_e'(wr_bank + 2'd1);   // A, B, C, D, A
            primed  <= 1'b1;
            if (primed) begin
               unit_sel <= !unit_sel;
            end
         end else if (dec_valid_i) begin
            wr_addr <= wr_addr + 1'b1;
         end
         busy <= busy | start_o;
      end
   end

   // output mux follows the registered ram read
   always_ff @(posedge clk) begin
      rd_bank_0_q <= rd_bank_0_i;
      rd_bank_1_q <= rd_bank_1_i;
   end

   // ----------------------------------------
   // survivor banks
   // ----------------------------------------
   for (genvar b = 0; b < viterbi_mem_pkg::NUM_BANKS; b++) begin : g_bank
      localparam viterbi_mem_pkg::bank_e BANK = viterbi_mem_pkg::bank_e'(b);

      decision_ram #(
         .TB_DEPTH (TB_DEPTH)
      ) decision_ram_i (
         .clk       (clk),
         .wr_en_i   (dec_valid_i && wr_bank == BANK),
         .wr_addr_i (wr_addr),
         .wr_data_i (decision_i),
         .rd_addr_i ((rd_bank_0_i == BANK) ? rd_addr_0_i : rd_addr_1_i),   // unit 0 first
         .rd_data_o (bank_rd_data[b])
      );
   end

   assign rd_data_0_o = bank_rd_data[rd_bank_0_q];
   assign rd_data_1_o = bank_rd_data[rd_bank_1_q];

   // both units running means they hold different banks
   assert property (@(posedge clk) disable iff (!rst)
      &busy |-> rd_bank_0_i != rd_bank_1_i)
      else $error("survivor_memory: read bank clash");

   // traceback stays off the bank under write
   assert property (@(posedge clk) disable iff (!rst)
      busy[0] && dec_valid_i |-> rd_bank_0_i != wr_bank)
      else $error("survivor_memory: unit 0 reads write bank");
   assert property (@(posedge clk) disable iff (!rst)
      busy[1] && dec_valid_i |-> rd_bank_1_i != wr_bank)
      else $error("survivor_memory: unit 1 reads write bank");

endmodule

`default_nettype wire

// File: src/traceback_unit.sv
`timescale 1ns/1ps
`default_nettype none

module traceback_unit #(
   parameter  int TB_DEPTH = 16,
   localparam int ADDR_W   = $clog2(TB_DEPTH)
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        enable_i,
   input  logic                        start_i,
   input  viterbi_mem_pkg::bank_e      train_bank_i,
   input  viterbi_mem_pkg::bank_e      dec_bank_i,
   output viterbi_mem_pkg::bank_e      rd_bank_o,
   output logic [ADDR_W-1:0]           rd_addr_o,
   input  viterbi_code_pkg::decision_t rd_data_i,
   output logic                        bit_o,
   output logic                        bit_valid_o,
   output logic                        last_o
);

   localparam int SW = viterbi_code_pkg::STATE_W;

   viterbi_mem_pkg::tb_phase_e phase;        // address side
   viterbi_mem_pkg::tb_phase_e data_phase;   // entry now on rd_data_i
   logic                       data_last;
   logic                       at_end;
   viterbi_mem_pkg::bank_e     dec_bank_q;
   viterbi_code_pkg::state_t   state;

   assign at_end = rd_addr_o == '0;

   // ----------------------------------------
   // phase FSM and address down-counter
   // ----------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         phase      <= viterbi_mem_pkg::TB_IDLE;
         rd_addr_o  <= '0;
         rd_bank_o  <= viterbi_mem_pkg::BANK_A;
         dec_bank_q <= viterbi_mem_pkg::BANK_A;
      end else if (!enable_i) begin
         phase      <= viterbi_mem_pkg::TB_IDLE;
         rd_addr_o  <= '0;
         rd_bank_o  <= viterbi_mem_pkg::BANK_A;
      end else if (start_i) begin
         phase      <= viterbi_mem_pkg::TB_TRAIN;
         rd_addr_o  <= ADDR_W'(TB_DEPTH - 1);   // newest entry first
         rd_bank_o  <= train_bank_i;
         dec_bank_q <= dec_bank_i;
      end else if (phase != viterbi_mem_pkg::TB_IDLE) begin
         if (at_end) begin
            rd_addr_o <= ADDR_W'(TB_DEPTH - 1);
            rd_bank_o <= dec_bank_q;
            phase     <= (phase == viterbi_mem_pkg::TB_TRAIN) ? viterbi_mem_pkg::TB_DECODE
                                                              : viterbi_mem_pkg::TB_IDLE;
         end else begin
            rd_addr_o <= rd_addr_o - 1'b1;
         end
      end
   end

   // ----------------------------------------
   // state walk, one ram latency behind
   // ----------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         data_phase  <= viterbi_mem_pkg::TB_IDLE;
         data_last   <= 1'b0;
         state       <= '0;
         bit_o       <= 1'b0;
         bit_valid_o <= 1'b0;
         last_o      <= 1'b0;
      end else if (!enable_i) begin
         data_phase  <= viterbi_mem_pkg::TB_IDLE;
         data_last   <= 1'b0;
         state       <= '0;
         bit_valid_o <= 1'b0;
         last_o      <= 1'b0;
      end else begin
         data_phase  <= phase;
         data_last   <= phase == viterbi_mem_pkg::TB_DECODE && at_end;
         bit_o       <= state[SW-1];   // input that led into this state
         bit_valid_o <= data_phase == viterbi_mem_pkg::TB_DECODE;
         last_o      <= data_last;
         if (data_last) begin
            state <= '0;   // next block starts from state 0
         end else if (data_phase != viterbi_mem_pkg::TB_IDLE) begin
            state <= {state[SW-2:0], rd_data_i[state]};
         end
      end
   end

   // a restart lands only on an idle unit or on its final decode step
   assert property (@(posedge clk) disable iff (!rst)
      start_i |-> phase == viterbi_mem_pkg::TB_IDLE ||
                  (phase == viterbi_mem_pkg::TB_DECODE && at_end))
      else $error("traceback_unit: start while busy");

endmodule

`default_nettype wire

// File: src/output_reorder.sv
`timescale 1ns/1ps
`default_nettype none

module output_reorder #(
   parameter  int TB_DEPTH = 16,
   localparam int ADDR_W   = $clog2(TB_DEPTH)
) (
   input  logic clk,
   input  logic rst,
   input  logic enable_i,
   input  logic bit_0_i,
   input  logic valid_0_i,
   input  logic last_0_i,
   input  logic bit_1_i,
   input  logic valid_1_i,
   input  logic last_1_i,
   output logic bit_o,
   output logic bit_valid_o
);

   viterbi_mem_pkg::side_e wr_side;   // read side is the other one
   logic [TB_DEPTH-1:0]    buf_0;
   logic [TB_DEPTH-1:0]    buf_1;
   logic [ADDR_W-1:0]      wr_ptr;
   logic [ADDR_W-1:0]      rd_ptr;
   logic                   rd_active;
   logic                   in_bit;
   logic                   in_valid;
   logic                   in_last;

   assign in_valid = valid_0_i | valid_1_i;
   assign in_bit   = valid_0_i ? bit_0_i : bit_1_i;
   assign in_last  = valid_0_i ? last_0_i : last_1_i;

   always_ff @(posedge clk) begin
      if (in_valid && wr_side == viterbi_mem_pkg::SIDE_0) buf_0[wr_ptr] <= in_bit;
      if (in_valid && wr_side == viterbi_mem_pkg::SIDE_1) buf_1[wr_ptr] <= in_bit;
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wr_side     <= viterbi_mem_pkg::SIDE_0;
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         rd_active   <= 1'b0;
         bit_o       <= 1'b0;
         bit_valid_o <= 1'b0;
      end else if (!enable_i) begin
         wr_side     <= viterbi_mem_pkg::SIDE_0;
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         rd_active   <= 1'b0;
         bit_valid_o <= 1'b0;
      end else begin
         if (in_valid) begin
            wr_ptr <= in_last ? '0 : wr_ptr + 1'b1;
         end
         if (in_valid && in_last) begin   // block complete, swap and replay it
            wr_side   <= (wr_side == viterbi_mem_pkg::SIDE_0) ? viterbi_mem_pkg::SIDE_1
                                                              : viterbi_mem_pkg::SIDE_0;
            rd_ptr    <= ADDR_W'(TB_DEPTH - 1);
            rd_active <= 1'b1;
         end else if (rd_active) begin
            rd_ptr    <= rd_ptr - 1'b1;
            rd_active <= rd_ptr != '0;
         end
         bit_valid_o <= rd_active;
         bit_o       <= (wr_side == viterbi_mem_pkg::SIDE_0) ? buf_1[rd_ptr] : buf_0[rd_ptr];
      end
   end

   // the traceback units take turns decoding
   assert property (@(posedge clk) disable iff (!rst) !(valid_0_i && valid_1_i))
      else $error("output_reorder: both units decoding");

endmodule

`default_nettype wire

// File: src/viterbi_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module viterbi_decoder #(
   parameter int TB_DEPTH = 16
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   enable_i,
   input  viterbi_code_pkg::sym_t sym_i,
   output logic                   bit_o,
   output logic                   bit_valid_o
);

   localparam int ADDR_W = $clog2(TB_DEPTH);

   viterbi_code_pkg::decision_t decision;
   logic                        dec_valid;
   logic [1:0]                  start;
   viterbi_mem_pkg::bank_e      train_bank;
   viterbi_mem_pkg::bank_e      dec_bank;
   viterbi_mem_pkg::bank_e      rd_bank_0;
   viterbi_mem_pkg::bank_e      rd_bank_1;
   logic [ADDR_W-1:0]           rd_addr_0;
   logic [ADDR_W-1:0]           rd_addr_1;
   viterbi_code_pkg::decision_t rd_data_0;
   viterbi_code_pkg::decision_t rd_data_1;
   logic                        tb_bit_0;
   logic                        tb_valid_0;
   logic                        tb_last_0;
   logic                        tb_bit_1;
   logic                        tb_valid_1;
   logic                        tb_last_1;

   // one symbol per enabled cycle, no stalls
   path_metric_unit path_metric_unit_i (
      .clk         (clk),
      .rst         (rst),
      .enable_i    (enable_i),
      .sym_i       (sym_i),
      .sym_valid_i (enable_i),
      .decision_o  (decision),
      .dec_valid_o (dec_valid)
   );

   survivor_memory #(
      .TB_DEPTH (TB_DEPTH)
   ) survivor_memory_i (
      .clk          (clk),
      .rst          (rst),
      .enable_i     (enable_i),
      .decision_i   (decision),
      .dec_valid_i  (dec_valid),
      .start_o      (start),
      .train_bank_o (train_bank),
      .dec_bank_o   (dec_bank),
      .rd_bank_0_i  (rd_bank_0),
      .rd_bank_1_i  (rd_bank_1),
      .rd_addr_0_i  (rd_addr_0),
      .rd_addr_1_i  (rd_addr_1),
      .rd_data_0_o  (rd_data_0),
      .rd_data_1_o  (rd_data_1)
   );

   traceback_unit #(
      .TB_DEPTH (TB_DEPTH)
   ) traceback_unit_0_i (
      .clk          (clk),
      .rst          (rst),
      .enable_i     (enable_i),
      .start_i      (start[0]),
      .train_bank_i (train_bank),
      .dec_bank_i   (dec_bank),
      .rd_bank_o    (rd_bank_0),
      .rd_addr_o    (rd_addr_0),
      .rd_data_i    (rd_data_0),
      .bit_o        (tb_bit_0),
      .bit_valid_o  (tb_valid_0),
      .last_o       (tb_last_0)
   );

   traceback_unit #(
      .TB_DEPTH (TB_DEPTH)
   ) traceback_unit_1_i (
      .clk          (clk),
      .rst          (rst),
      .enable_i     (enable_i),
      .start_i      (start[1]),
      .train_bank_i (train_bank),
      .dec_bank_i   (dec_bank),
      .rd_bank_o    (rd_bank_1),
      .rd_addr_o    (rd_addr_1),
      .rd_data_i    (rd_data_1),
      .bit_o        (tb_bit_1),
      .bit_valid_o  (tb_valid_1),
      .last_o       (tb_last_1)
   );

   output_reorder #(
      .TB_DEPTH (TB_DEPTH)
   ) output_reorder_i (
      .clk         (clk),
      .rst         (rst),
      .enable_i    (enable_i),
      .bit_0_i     (tb_bit_0),
      .valid_0_i   (tb_valid_0),
      .last_0_i    (tb_last_0),
      .bit_1_i     (tb_bit_1),
      .valid_1_i   (tb_valid_1),
      .last_1_i    (tb_last_1),
      .bit_o       (bit_o),
      .bit_valid_o (bit_valid_o)
   );

endmodule

`default_nettype wire

// File: tb/tb_ref_encoder.svh
`ifndef TB_REF_ENCODER_SVH
`define TB_REF_ENCODER_SVH

// ----------------------------------------
// reference encoder and channel model
// ----------------------------------------

// generator taps, bit order {input bit, s2, s1, s0}
localparam logic [3:0] REF_GEN_0 = 4'b1111;
localparam logic [3:0] REF_GEN_1 = 4'b1101;

logic [2:0] enc_state;        // s2 is the newest input
logic       expected_q [$];   // bits the decoder still owes
integer     seed;

// channel symbol for input b leaving state st
function automatic logic [1:0] encode_bit(input logic b, input logic [2:0] st);
   logic [3:0] taps;
   taps = {b, st};
   return {^(taps & REF_GEN_1), ^(taps & REF_GEN_0)};
endfunction

// fresh stream from state 0
task automatic restart_encoder();
   enc_state = 3'b000;
   out_count = 0;
   expected_q.delete();
endtask

// one symbol per falling edge, flip marks channel bits to invert
task automatic send_bit(input logic b, input logic [1:0] flip);
   @(negedge clk);
   enable    = 1'b1;
   sym       = encode_bit(b, enc_state) ^ flip;
   enc_state = {b, enc_state[2:1]};   // next state (b, s2, s1)
   expected_q.push_back(b);
endtask

// random data then zero flush, one flip every flip_gap symbols if flip_gap > 0
task automatic send_stream(input int n_bits, input int flip_gap, input int n_flush);
   logic       b;
   logic [1:0] flip;
   logic [31:0] rnd;
   for (int i = 0; i < n_bits + n_flush; i++) begin
      rnd  = $random(seed);
      b    = (i < n_bits) ? rnd[0] : 1'b0;
      flip = 2'b00;
      if (flip_gap > 0 && i % flip_gap == flip_gap / 2) begin
         flip = rnd[1] ? 2'b10 : 2'b01;   // single channel bit
      end
      send_bit(b, flip);
   end
endtask

`endif

// File: tb/tb_viterbi_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_viterbi_decoder;

   localparam int TB_DEPTH  = 16;
   localparam int FLUSH     = 4 * TB_DEPTH;
   localparam int NORM_BITS = 3000;   // enough flips to push every metric past half range

   logic       clk;
   logic       rst;
   logic       enable;
   logic [1:0] sym;
   logic       bit_out;
   logic       bit_valid;
   string      test_name;
   int         out_count;     // decoded bits seen in this stream
   int         error_count;
   logic       exp_bit;

   `include "tb_ref_encoder.svh"

   viterbi_decoder #(
      .TB_DEPTH (TB_DEPTH)
   ) viterbi_decoder_i (
      .clk         (clk),
      .rst         (rst),
      .enable_i    (enable),
      .sym_i       (sym),
      .bit_o       (bit_out),
      .bit_valid_o (bit_valid)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         error_count++;
         $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
         $display("sim failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // output monitor
   always @(negedge clk) begin
      if (bit_valid) begin
         if (expected_q.size() == 0) begin
            $display("decoded bit in %s arrived with no expected bit left", test_name);
            $display("sim failed");
            $fatal(1, "unexpected output");
         end else begin
            exp_bit = expected_q.pop_front();
            out_count++;
            check_value(test_name, exp_bit, bit_out);
         end
      end
   end

   // keep feeding zeros until n_bits decoded bits came out
   task automatic wait_for_bits(input int n_bits);
      int cycles;
      cycles = 0;
      while (out_count < n_bits && cycles < 8 * TB_DEPTH + 100) begin
         send_bit(1'b0, 2'b00);
         cycles++;
      end
      if (out_count < n_bits) begin
         $display("timeout in %s: only %0d of %0d decoded bits seen",
                  test_name, out_count, n_bits);
         $display("sim failed");
         $fatal(1, "timeout");
      end
   endtask

   // drop enable and expect a quiet output
   task automatic stop_stream(input int n_cycles);
      @(negedge clk);
      enable = 1'b0;
      sym    = 2'b00;
      repeat (n_cycles) begin
         @(negedge clk);
         check_value(test_name, 0, bit_valid);
      end
      restart_encoder();
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic test_reset();
      test_name = "reset";
      repeat (8) begin
         @(negedge clk);
         check_value(test_name, 0, bit_valid);
      end
      rst = 1'b1;
      restart_encoder();
      // first bank cannot produce output yet
      repeat (TB_DEPTH) begin
         send_stream(1, 0, 0);
         check_value(test_name, 0, bit_valid);
      end
      @(negedge clk);
      check_value(test_name, 0, bit_valid);
      stop_stream(3);
   endtask

   task automatic test_clean_stream();
      test_name = "clean_stream";
      send_stream(64, 0, FLUSH);
      wait_for_bits(64);
      stop_stream(3);
   endtask

   task automatic test_error_correction();
      test_name = "error_correction";
      send_stream(128, 20, FLUSH);
      wait_for_bits(128);
      stop_stream(3);
   endtask

   task automatic test_normalization();
      test_name = "normalization";
      send_stream(NORM_BITS, 20, FLUSH);
      wait_for_bits(NORM_BITS);
      stop_stream(3);
   endtask

   task automatic test_restart();
      test_name = "restart";
      send_stream(8 * TB_DEPTH, 0, 0);   // outputs already flowing at the drop
      stop_stream(5);
      send_stream(64, 0, FLUSH);
      wait_for_bits(64);
      stop_stream(3);
   endtask

   initial begin
      rst         = 1'b0;
      enable      = 1'b0;
      sym         = 2'b00;
      seed        = 6599;
      error_count = 0;
      out_count   = 0;
      test_name   = "init";
      enc_state   = 3'b000;
      test_reset();
      test_clean_stream();
      test_error_correction();
      test_normalization();
      test_restart();
      if (error_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+tb
src/viterbi_code_pkg.sv
src/viterbi_mem_pkg.sv
src/decision_ram.sv
src/path_metric_unit.sv
src/survivor_memory.sv
src/traceback_unit.sv
src/output_reorder.sv
src/viterbi_decoder.sv
tb/tb_viterbi_decoder.sv
